// ==== src/floo_group_pkg.sv ====
// Shared widths, identifier types and stream structs of the group network
// Request and response structs on both sides of the packing, plus flit formats
package floo_group_pkg;

  localparam int unsigned NumTiles      = 2;
  localparam int unsigned TileIdWidth   = 1;
  localparam int unsigned BankRowWidth  = 8;  // 6 row bits, 2 bank bits
  localparam int unsigned TgtAddrWidth  = BankRowWidth + TileIdWidth;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned CoreIdWidth   = 3;
  localparam int unsigned MetaIdWidth   = 4;
  localparam int unsigned NumDirections = 5;

  typedef logic [TileIdWidth-1:0]  tile_id_t;
  typedef logic [BankRowWidth-1:0] bank_row_t;
  typedef logic [TgtAddrWidth-1:0] tgt_addr_t;  // Row, bank, tile
  typedef logic [DataWidth-1:0]    word_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [CoreIdWidth-1:0]  core_id_t;
  typedef logic [MetaIdWidth-1:0]  meta_id_t;

  // Position of a group in the 4 by 4 mesh
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } group_xy_id_t;

  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  typedef logic [West:North] link_bits_t;  // One bit per mesh link

  typedef struct packed {
    logic         wen;
    be_t          be;
    word_t        data;
    core_id_t     core_id;
    meta_id_t     meta_id;
    tgt_addr_t    tgt_addr;
    group_xy_id_t tgt_group;
  } tcdm_req_t;

  typedef struct packed {
    logic         wen;
    be_t          be;
    word_t        data;
    core_id_t     core_id;
    meta_id_t     meta_id;
    bank_row_t    tgt_addr;  // Tile bits already stripped
    tile_id_t     ini_tile;
    group_xy_id_t src_group;
  } tcdm_slv_req_t;

  typedef struct packed {
    word_t        data;
    core_id_t     core_id;
    meta_id_t     meta_id;
    tile_id_t     ini_tile;
    group_xy_id_t src_group;
  } tcdm_slv_resp_t;

  typedef struct packed {
    word_t    data;
    core_id_t core_id;
    meta_id_t meta_id;
  } tcdm_resp_t;

  typedef struct packed {
    group_xy_id_t dst_id;
    group_xy_id_t src_id;
    tile_id_t     src_tile;  // Steers the response crossbar on return
    tgt_addr_t    tgt_addr;
    core_id_t     core_id;
    meta_id_t     meta_id;
  } req_hdr_t;

  typedef struct packed {
    logic  wen;
    be_t   be;
    word_t data;
  } req_payload_t;

  typedef struct packed {
    req_hdr_t     hdr;
    req_payload_t payload;
  } req_flit_t;

  typedef struct packed {
    group_xy_id_t dst_id;
    tile_id_t     tile_id;
    core_id_t     core_id;
    meta_id_t     meta_id;
  } resp_hdr_t;

  typedef struct packed {
    word_t data;
  } resp_payload_t;

  typedef struct packed {
    resp_hdr_t     hdr;
    resp_payload_t payload;
  } resp_flit_t;

  // Flits on the four mesh links of one tile
  typedef req_flit_t  [West:North] req_links_t;
  typedef resp_flit_t [West:North] resp_links_t;

endpackage

// ==== src/stream_fifo.sv ====
// Small circular-buffer FIFO with valid/ready handshakes on both sides
module stream_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         data_t = logic
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  data_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output data_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  data_t                mem [Depth];
  logic  [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic  [CntWidth-1:0] count_q;
  logic                 push, pop;

  assign ready_o = (count_q != CntWidth'(Depth));  // Full blocks even with a pop
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= data_i;
  end

endmodule

// ==== src/rr_arbiter.sv ====
// Round-robin arbiter with a combinational one-hot grant
// The grant holds while the winner waits for ready
module rr_arbiter #(
  parameter int unsigned NumReq = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [NumReq-1:0] req_i,
  output logic [NumReq-1:0] grant_o,
  output logic              valid_o,
  input  logic              ready_i
);

  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxWidth-1:0] ptr_q, win_idx;
  logic [NumReq-1:0]   rr_grant, held_grant_q;
  logic                lock_q;

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    found    = 1'b0;
    rr_grant = '0;
    for (int unsigned off = 0; off < NumReq; off++) begin
      idx = (ptr_q + off) % NumReq;
      if (!found && req_i[idx]) begin
        found         = 1'b1;
        rr_grant[idx] = 1'b1;
      end
    end
  end

  assign grant_o = lock_q ? held_grant_q : rr_grant;  // Keep the stalled winner
  assign valid_o = |req_i;

  always_comb begin
    win_idx = '0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      if (grant_o[i]) win_idx = IdxWidth'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o && !ready_i;
      if (valid_o && ready_i) begin
        ptr_q <= (win_idx == IdxWidth'(NumReq - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    held_grant_q <= grant_o;
  end

endmodule

// ==== src/floo_xy_router.sv ====
// Five-port mesh router with buffered inputs and XY dimension-order routing
// Port 0 is the local port, ports 1 to 4 are North, East, South and West
module floo_xy_router #(
  parameter type         flit_t    = floo_group_pkg::req_flit_t,
  parameter int unsigned FifoDepth = 2
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  floo_group_pkg::group_xy_id_t                   xy_id_i,
  // Incoming links
  input  flit_t [floo_group_pkg::NumDirections-1:0]      data_i,
  input  logic  [floo_group_pkg::NumDirections-1:0]      valid_i,
  output logic  [floo_group_pkg::NumDirections-1:0]      ready_o,
  // Outgoing links
  output flit_t [floo_group_pkg::NumDirections-1:0]      data_o,
  output logic  [floo_group_pkg::NumDirections-1:0]      valid_o,
  input  logic  [floo_group_pkg::NumDirections-1:0]      ready_i
);

  import floo_group_pkg::*;

  flit_t      [NumDirections-1:0]                    buf_data;
  logic       [NumDirections-1:0]                    buf_valid;
  logic       [NumDirections-1:0]                    buf_ready;
  route_dir_e [NumDirections-1:0]                    route;
  // Indexed [output][input]
  logic       [NumDirections-1:0][NumDirections-1:0] arb_req;
  logic       [NumDirections-1:0][NumDirections-1:0] arb_grant;

  // X first, then Y, then eject
  function automatic route_dir_e xy_route(group_xy_id_t dst, group_xy_id_t own);
    route_dir_e dir;
    if (dst.x > own.x) begin
      dir = East;
    end else if (dst.x < own.x) begin
      dir = West;
    end else if (dst.y > own.y) begin
      dir = North;
    end else if (dst.y < own.y) begin
      dir = South;
    end else begin
      dir = Local;
    end
    return dir;
  endfunction

  for (genvar i = 0; i < NumDirections; i++) begin : gen_input
    stream_fifo #(
      .Depth  (FifoDepth),
      .data_t (flit_t)
    ) i_in_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .data_i  (data_i[i]),
      .valid_i (valid_i[i]),
      .ready_o (ready_o[i]),
      .data_o  (buf_data[i]),
      .valid_o (buf_valid[i]),
      .ready_i (buf_ready[i])
    );

    assign route[i] = xy_route(buf_data[i].hdr.dst_id, xy_id_i);

    // Pop once the granted output takes the flit
    assign buf_ready[i] = ready_i[route[i]] && arb_grant[route[i]][i];
  end

  for (genvar o = 0; o < NumDirections; o++) begin : gen_output
    for (genvar i = 0; i < NumDirections; i++) begin : gen_req
      assign arb_req[o][i] = buf_valid[i] && (route[i] == o);
    end

    rr_arbiter #(
      .NumReq (NumDirections)
    ) i_out_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (arb_req[o]),
      .grant_o (arb_grant[o]),
      .valid_o (valid_o[o]),
      .ready_i (ready_i[o])
    );
  end

  // One-hot output mux
  always_comb begin
    data_o = '0;
    for (int o = 0; o < NumDirections; o++) begin
      for (int i = 0; i < NumDirections; i++) begin
        if (arb_grant[o][i]) begin
          data_o[o] = buf_data[i];
        end
      end
    end
  end

endmodule

// ==== src/tile_xbar.sv ====
// Crossbar from the local router outputs to the tiles of the group
// Each output round-robins among the inputs that select it
module tile_xbar #(
  parameter type flit_t = floo_group_pkg::req_flit_t
) (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  // From the routers
  input  flit_t                    [floo_group_pkg::NumTiles-1:0] data_i,
  input  floo_group_pkg::tile_id_t [floo_group_pkg::NumTiles-1:0] sel_i,
  input  logic                     [floo_group_pkg::NumTiles-1:0] valid_i,
  output logic                     [floo_group_pkg::NumTiles-1:0] ready_o,
  // To the tiles
  output flit_t                    [floo_group_pkg::NumTiles-1:0] data_o,
  output logic                     [floo_group_pkg::NumTiles-1:0] valid_o,
  input  logic                     [floo_group_pkg::NumTiles-1:0] ready_i
);

  import floo_group_pkg::*;

  // Indexed [output][input]
  logic [NumTiles-1:0][NumTiles-1:0] arb_req;
  logic [NumTiles-1:0][NumTiles-1:0] arb_grant;

  for (genvar o = 0; o < NumTiles; o++) begin : gen_out
    for (genvar i = 0; i < NumTiles; i++) begin : gen_req
      assign arb_req[o][i] = valid_i[i] && (sel_i[i] == tile_id_t'(o));
    end

    rr_arbiter #(
      .NumReq (NumTiles)
    ) i_tile_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (arb_req[o]),
      .grant_o (arb_grant[o]),
      .valid_o (valid_o[o]),
      .ready_i (ready_i[o])
    );
  end

  for (genvar i = 0; i < NumTiles; i++) begin : gen_in
    assign ready_o[i] = ready_i[sel_i[i]] && arb_grant[sel_i[i]][i];  // Only the winner moves
  end

  always_comb begin
    data_o = '0;
    for (int o = 0; o < NumTiles; o++) begin
      for (int i = 0; i < NumTiles; i++) begin
        if (arb_grant[o][i]) begin
          data_o[o] = data_i[i];
        end
      end
    end
  end

endmodule

// ==== src/group_noc_top.sv ====
// Network side of one group: request and response packing per tile,
// one request and one response XY router per tile, and two tile crossbars
module group_noc_top #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  input  floo_group_pkg::group_xy_id_t                             group_id_i,
  // Master side of each tile
  input  floo_group_pkg::tcdm_req_t      [floo_group_pkg::NumTiles-1:0] mst_req_i,
  input  logic                           [floo_group_pkg::NumTiles-1:0] mst_req_valid_i,
  output logic                           [floo_group_pkg::NumTiles-1:0] mst_req_ready_o,
  output floo_group_pkg::tcdm_resp_t     [floo_group_pkg::NumTiles-1:0] mst_resp_o,
  output logic                           [floo_group_pkg::NumTiles-1:0] mst_resp_valid_o,
  input  logic                           [floo_group_pkg::NumTiles-1:0] mst_resp_ready_i,
  // Slave side of each tile
  output floo_group_pkg::tcdm_slv_req_t  [floo_group_pkg::NumTiles-1:0] slv_req_o,
  output logic                           [floo_group_pkg::NumTiles-1:0] slv_req_valid_o,
  input  logic                           [floo_group_pkg::NumTiles-1:0] slv_req_ready_i,
  input  floo_group_pkg::tcdm_slv_resp_t [floo_group_pkg::NumTiles-1:0] slv_resp_i,
  input  logic                           [floo_group_pkg::NumTiles-1:0] slv_resp_valid_i,
  output logic                           [floo_group_pkg::NumTiles-1:0] slv_resp_ready_o,
  // Mesh links, per tile and direction
  output floo_group_pkg::req_links_t     [floo_group_pkg::NumTiles-1:0] req_flit_o,
  output floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] req_valid_o,
  input  floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] req_ready_i,
  input  floo_group_pkg::req_links_t     [floo_group_pkg::NumTiles-1:0] req_flit_i,
  input  floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] req_valid_i,
  output floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] req_ready_o,
  output floo_group_pkg::resp_links_t    [floo_group_pkg::NumTiles-1:0] resp_flit_o,
  output floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] resp_valid_o,
  input  floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] resp_ready_i,
  input  floo_group_pkg::resp_links_t    [floo_group_pkg::NumTiles-1:0] resp_flit_i,
  input  floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] resp_valid_i,
  output floo_group_pkg::link_bits_t     [floo_group_pkg::NumTiles-1:0] resp_ready_o
);

  import floo_group_pkg::*;

  req_flit_t  [NumTiles-1:0] req_inj_flit, req_ej_flit, req_xbar_flit;
  logic       [NumTiles-1:0] req_ej_valid, req_ej_ready;
  tile_id_t   [NumTiles-1:0] req_sel;
  resp_flit_t [NumTiles-1:0] resp_inj_flit, resp_ej_flit, resp_xbar_flit;
  logic       [NumTiles-1:0] resp_ej_valid, resp_ej_ready;
  tile_id_t   [NumTiles-1:0] resp_sel;

  for (genvar i = 0; i < NumTiles; i++) begin : gen_tile
    // Master request into a request flit
    assign req_inj_flit[i] = req_flit_t'{
      hdr: req_hdr_t'{
        dst_id:   mst_req_i[i].tgt_group,
        src_id:   group_id_i,
        src_tile: tile_id_t'(i),  // Return path inside the group
        tgt_addr: mst_req_i[i].tgt_addr,
        core_id:  mst_req_i[i].core_id,
        meta_id:  mst_req_i[i].meta_id
      },
      payload: req_payload_t'{
        wen:  mst_req_i[i].wen,
        be:   mst_req_i[i].be,
        data: mst_req_i[i].data
      }
    };

    assign req_sel[i] = req_ej_flit[i].hdr.tgt_addr[TileIdWidth-1:0];

    // Tile bits dropped since they already picked the slave
    assign slv_req_o[i] = tcdm_slv_req_t'{
      wen:       req_xbar_flit[i].payload.wen,
      be:        req_xbar_flit[i].payload.be,
      data:      req_xbar_flit[i].payload.data,
      core_id:   req_xbar_flit[i].hdr.core_id,
      meta_id:   req_xbar_flit[i].hdr.meta_id,
      tgt_addr:  req_xbar_flit[i].hdr.tgt_addr[TgtAddrWidth-1:TileIdWidth],
      ini_tile:  req_xbar_flit[i].hdr.src_tile,
      src_group: req_xbar_flit[i].hdr.src_id
    };

    // Slave response back towards the requesting group
    assign resp_inj_flit[i] = resp_flit_t'{
      hdr: resp_hdr_t'{
        dst_id:  slv_resp_i[i].src_group,
        tile_id: slv_resp_i[i].ini_tile,
        core_id: slv_resp_i[i].core_id,
        meta_id: slv_resp_i[i].meta_id
      },
      payload: resp_payload_t'{data: slv_resp_i[i].data}
    };

    assign resp_sel[i] = resp_ej_flit[i].hdr.tile_id;

    assign mst_resp_o[i] = tcdm_resp_t'{
      data:    resp_xbar_flit[i].payload.data,
      core_id: resp_xbar_flit[i].hdr.core_id,
      meta_id: resp_xbar_flit[i].hdr.meta_id
    };

    floo_xy_router #(
      .flit_t    (req_flit_t),
      .FifoDepth (FifoDepth)
    ) i_req_router (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .xy_id_i (group_id_i),
      .data_i  ({req_flit_i[i], req_inj_flit[i]}),  // Links on top, local at index 0
      .valid_i ({req_valid_i[i], mst_req_valid_i[i]}),
      .ready_o ({req_ready_o[i], mst_req_ready_o[i]}),
      .data_o  ({req_flit_o[i], req_ej_flit[i]}),
      .valid_o ({req_valid_o[i], req_ej_valid[i]}),
      .ready_i ({req_ready_i[i], req_ej_ready[i]})
    );

    floo_xy_router #(
      .flit_t    (resp_flit_t),
      .FifoDepth (FifoDepth)
    ) i_resp_router (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .xy_id_i (group_id_i),
      .data_i  ({resp_flit_i[i], resp_inj_flit[i]}),
      .valid_i ({resp_valid_i[i], slv_resp_valid_i[i]}),
      .ready_o ({resp_ready_o[i], slv_resp_ready_o[i]}),
      .data_o  ({resp_flit_o[i], resp_ej_flit[i]}),
      .valid_o ({resp_valid_o[i], resp_ej_valid[i]}),
      .ready_i ({resp_ready_i[i], resp_ej_ready[i]})
    );
  end

  tile_xbar #(
    .flit_t (req_flit_t)
  ) i_req_xbar (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (req_ej_flit),
    .sel_i   (req_sel),
    .valid_i (req_ej_valid),
    .ready_o (req_ej_ready),
    .data_o  (req_xbar_flit),
    .valid_o (slv_req_valid_o),
    .ready_i (slv_req_ready_i)
  );

  tile_xbar #(
    .flit_t (resp_flit_t)
  ) i_resp_xbar (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (resp_ej_flit),
    .sel_i   (resp_sel),
    .valid_i (resp_ej_valid),
    .ready_o (resp_ej_ready),
    .data_o  (resp_xbar_flit),
    .valid_o (mst_resp_valid_o),
    .ready_i (mst_resp_ready_i)
  );

endmodule

// ==== dv/tb_group_noc.sv ====
// Testbench for the group network: reset, local and remote requests,
// link traffic, response return and back-pressure, checked by assertions
module tb_group_noc;

  import floo_group_pkg::*;

  localparam int unsigned MaxCycles = 3000;

  logic clk_i;
  logic reset_i;
  group_xy_id_t group_id_i;

  tcdm_req_t      [NumTiles-1:0] mst_req_i;
  logic           [NumTiles-1:0] mst_req_valid_i, mst_req_ready_o;
  tcdm_resp_t     [NumTiles-1:0] mst_resp_o;
  logic           [NumTiles-1:0] mst_resp_valid_o, mst_resp_ready_i;
  tcdm_slv_req_t  [NumTiles-1:0] slv_req_o;
  logic           [NumTiles-1:0] slv_req_valid_o, slv_req_ready_i;
  tcdm_slv_resp_t [NumTiles-1:0] slv_resp_i;
  logic           [NumTiles-1:0] slv_resp_valid_i, slv_resp_ready_o;
  req_links_t     [NumTiles-1:0] req_flit_o, req_flit_i;
  link_bits_t     [NumTiles-1:0] req_valid_o, req_ready_i, req_valid_i, req_ready_o;
  resp_links_t    [NumTiles-1:0] resp_flit_o, resp_flit_i;
  link_bits_t     [NumTiles-1:0] resp_valid_o, resp_ready_i, resp_valid_i, resp_ready_o;

  // Expected streams with slave requests split by slave and source tile
  tcdm_slv_req_t exp_slv       [NumTiles][NumTiles][$];
  tcdm_resp_t    exp_mst_resp  [NumTiles][$];
  req_flit_t     exp_req_link  [NumTiles][NumDirections][$];
  resp_flit_t    exp_resp_link [NumTiles][NumDirections][$];

  int unsigned cycle;
  logic        reset_d;
  logic        saw_stall;
  logic [31:0] lcg_state;

  group_noc_top #(.FifoDepth(2)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("[ERROR] %0t %s", $time, msg));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // XY rule seen from group (1,1)
  function automatic int route_of(group_xy_id_t dst);
    if (dst.x > 2'd1) return 2;  // East
    if (dst.x < 2'd1) return 4;  // West
    if (dst.y > 2'd1) return 1;  // North
    if (dst.y < 2'd1) return 3;  // South
    return 0;
  endfunction

  function automatic tcdm_req_t rand_req(input group_xy_id_t grp, input logic tile_bit);
    tcdm_req_t   r;
    logic [31:0] v;
    v           = lcg_next();
    r.wen       = v[0];
    r.be        = v[7:4];
    r.core_id   = v[10:8];
    r.meta_id   = v[14:11];
    r.tgt_addr  = {v[23:16], tile_bit};
    r.data      = lcg_next();
    r.tgt_group = grp;
    return r;
  endfunction

  function automatic req_flit_t flit_of(input tcdm_req_t r, input int t);
    req_flit_t f;
    f.hdr.dst_id     = r.tgt_group;
    f.hdr.src_id     = group_id_i;
    f.hdr.src_tile   = tile_id_t'(t);
    f.hdr.tgt_addr   = r.tgt_addr;
    f.hdr.core_id    = r.core_id;
    f.hdr.meta_id    = r.meta_id;
    f.payload.wen    = r.wen;
    f.payload.be     = r.be;
    f.payload.data   = r.data;
    return f;
  endfunction

  // Flit leaving the request router of tile t
  function automatic void expect_req_flit(input int t, input req_flit_t f);
    tcdm_slv_req_t s;
    int            dir;
    dir = route_of(f.hdr.dst_id);
    if (dir != 0) begin
      exp_req_link[t][dir].push_back(f);
    end else begin
      s.wen       = f.payload.wen;
      s.be        = f.payload.be;
      s.data      = f.payload.data;
      s.core_id   = f.hdr.core_id;
      s.meta_id   = f.hdr.meta_id;
      s.tgt_addr  = f.hdr.tgt_addr >> 1;
      s.ini_tile  = f.hdr.src_tile;
      s.src_group = f.hdr.src_id;
      exp_slv[f.hdr.tgt_addr[0]][f.hdr.src_tile].push_back(s);
    end
  endfunction

  // Flit leaving the response router of tile t
  function automatic void expect_resp_flit(input int t, input resp_flit_t f);
    tcdm_resp_t m;
    int         dir;
    dir = route_of(f.hdr.dst_id);
    if (dir != 0) begin
      exp_resp_link[t][dir].push_back(f);
    end else begin
      m.data    = f.payload.data;
      m.core_id = f.hdr.core_id;
      m.meta_id = f.hdr.meta_id;
      exp_mst_resp[f.hdr.tile_id].push_back(m);
    end
  endfunction

  task automatic send_mst(input int t, input tcdm_req_t r);
    expect_req_flit(t, flit_of(r, t));
    mst_req_i[t] = r;
    mst_req_valid_i[t] = 1'b1;
    @(posedge clk_i);
    while (!mst_req_ready_o[t]) @(posedge clk_i);
    #1 mst_req_valid_i[t] = 1'b0;
  endtask

  task automatic send_link_req(input int t, input int d, input req_flit_t f);
    expect_req_flit(t, f);
    req_flit_i[t][d] = f;
    req_valid_i[t][d] = 1'b1;
    @(posedge clk_i);
    while (!req_ready_o[t][d]) @(posedge clk_i);
    #1 req_valid_i[t][d] = 1'b0;
  endtask

  task automatic send_slv_resp(input int t, input tcdm_slv_resp_t r);
    resp_flit_t f;
    f.hdr.dst_id       = r.src_group;
    f.hdr.tile_id      = r.ini_tile;
    f.hdr.core_id      = r.core_id;
    f.hdr.meta_id      = r.meta_id;
    f.payload.data     = r.data;
    expect_resp_flit(t, f);
    slv_resp_i[t] = r;
    slv_resp_valid_i[t] = 1'b1;
    @(posedge clk_i);
    while (!slv_resp_ready_o[t]) @(posedge clk_i);
    #1 slv_resp_valid_i[t] = 1'b0;
  endtask

  task automatic send_link_resp(input int t, input int d, input resp_flit_t f);
    expect_resp_flit(t, f);
    resp_flit_i[t][d] = f;
    resp_valid_i[t][d] = 1'b1;
    @(posedge clk_i);
    while (!resp_ready_o[t][d]) @(posedge clk_i);
    #1 resp_valid_i[t][d] = 1'b0;
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int t = 0; t < NumTiles; t++) begin
      n += exp_mst_resp[t].size();
      for (int s = 0; s < NumTiles; s++) n += exp_slv[t][s].size();
      for (int d = 0; d < NumDirections; d++) begin
        n += exp_req_link[t][d].size() + exp_resp_link[t][d].size();
      end
    end
    return n;
  endfunction

  // Every output handshake must match the head of its queue
  always @(posedge clk_i) begin
    tcdm_slv_req_t exp_s;
    tcdm_resp_t    exp_m;
    req_flit_t     exp_rq;
    resp_flit_t    exp_rs;
    logic          hit;
    if (cycle > 0 && (reset_i || reset_d)) begin
      assert (slv_req_valid_o == '0 && mst_resp_valid_o == '0 &&
              req_valid_o == '0 && resp_valid_o == '0)
        else report_error("valid output high during or right after reset");
    end
    for (int t = 0; t < NumTiles; t++) begin
      if (mst_req_valid_i[t] && !mst_req_ready_o[t]) saw_stall = 1'b1;
      if (slv_req_valid_o[t] && slv_req_ready_i[t]) begin
        hit = exp_slv[t][slv_req_o[t].ini_tile].size() > 0;
        if (hit) exp_s = exp_slv[t][slv_req_o[t].ini_tile].pop_front();
        assert (hit && slv_req_o[t] == exp_s)
          else report_error($sformatf("unexpected slave request on tile %0d", t));
      end
      if (mst_resp_valid_o[t] && mst_resp_ready_i[t]) begin
        hit = exp_mst_resp[t].size() > 0;
        if (hit) exp_m = exp_mst_resp[t].pop_front();
        assert (hit && mst_resp_o[t] == exp_m)
          else report_error($sformatf("unexpected master response on tile %0d", t));
      end
      for (int d = 1; d < NumDirections; d++) begin
        if (req_valid_o[t][d] && req_ready_i[t][d]) begin
          hit = exp_req_link[t][d].size() > 0;
          if (hit) exp_rq = exp_req_link[t][d].pop_front();
          assert (hit && req_flit_o[t][d] == exp_rq)
            else report_error($sformatf("unexpected request flit tile %0d dir %0d", t, d));
        end
        if (resp_valid_o[t][d] && resp_ready_i[t][d]) begin
          hit = exp_resp_link[t][d].size() > 0;
          if (hit) exp_rs = exp_resp_link[t][d].pop_front();
          assert (hit && resp_flit_o[t][d] == exp_rs)
            else report_error($sformatf("unexpected response flit tile %0d dir %0d", t, d));
        end
      end
    end
    reset_d <= reset_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= MaxCycles) abort_run("Timeout: the run did not finish within 3000 cycles");
  end

  initial begin
    tcdm_req_t      r;
    req_flit_t      f;
    tcdm_slv_resp_t sr;
    resp_flit_t     rf;
    cycle = 0;
    reset_d = 1'b1;
    saw_stall = 1'b0;
    lcg_state = 32'd6;
    reset_i = 1'b1;
    group_id_i = '{x: 2'd1, y: 2'd1};
    mst_req_i = '0;
    mst_req_valid_i = '0;
    mst_resp_ready_i = '1;
    slv_req_ready_i = '1;
    slv_resp_i = '0;
    slv_resp_valid_i = '0;
    req_flit_i = '0;
    req_valid_i = '0;
    req_ready_i = '1;
    resp_flit_i = '0;
    resp_valid_i = '0;
    resp_ready_i = '1;
    repeat (16) @(posedge clk_i);
    #1 reset_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;

    // Local request reaches the slave one cycle later
    send_mst(0, rand_req('{x: 2'd1, y: 2'd1}, 1'b1));
    @(posedge clk_i);
    assert (slv_req_valid_o[1]) else report_error("local request not at slave after 1 cycle");
    #1;

    // Remote routing from both tiles
    for (int t = 0; t < NumTiles; t++) begin
      send_mst(t, rand_req('{x: 2'd3, y: 2'd0}, lcg_next() & 1));
      send_mst(t, rand_req('{x: 2'd0, y: 2'd2}, lcg_next() & 1));
      send_mst(t, rand_req('{x: 2'd1, y: 2'd3}, lcg_next() & 1));
      send_mst(t, rand_req('{x: 2'd1, y: 2'd0}, lcg_next() & 1));
    end
    f = flit_of(rand_req('{x: 2'd2, y: 2'd1}, 1'b0), 1);
    f.hdr.src_id = '{x: 2'd0, y: 2'd1};
    send_link_req(1, 1, f);  // Passes through East

    // Incoming from West, then the slave answers back West
    f = flit_of(rand_req('{x: 2'd1, y: 2'd1}, 1'b0), 1);
    f.hdr.src_id = '{x: 2'd0, y: 2'd1};
    send_link_req(0, 4, f);
    sr.data = lcg_next();
    sr.core_id = f.hdr.core_id;
    sr.meta_id = f.hdr.meta_id;
    sr.ini_tile = f.hdr.src_tile;
    sr.src_group = f.hdr.src_id;
    send_slv_resp(0, sr);
    sr.data = lcg_next();
    sr.ini_tile = 1'b0;
    sr.src_group = '{x: 2'd1, y: 2'd1};
    send_slv_resp(1, sr);  // Local response to tile 0

    // Response flit from the East link of tile 1, delivered to tile 0
    rf.hdr.dst_id = '{x: 2'd1, y: 2'd1};
    rf.hdr.tile_id = 1'b0;
    rf.hdr.core_id = 3'd5;
    rf.hdr.meta_id = 4'd9;
    rf.payload.data = lcg_next();
    send_link_resp(1, 2, rf);

    // Back-pressure on slave 1
    slv_req_ready_i[1] = 1'b0;
    fork
      repeat (8) send_mst(0, rand_req('{x: 2'd1, y: 2'd1}, 1'b1));
      repeat (8) send_mst(1, rand_req('{x: 2'd1, y: 2'd1}, 1'b1));
      begin
        repeat (40) @(posedge clk_i);
        #1 slv_req_ready_i[1] = 1'b1;
      end
    join
    assert (saw_stall) else report_error("mst_req_ready_o never fell under back-pressure");

    // Drain until every expected transfer has been seen
    while (pending() != 0) begin
      @(posedge clk_i);
      #1;
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== filelist.f ====
src/floo_group_pkg.sv
src/stream_fifo.sv
src/rr_arbiter.sv
src/floo_xy_router.sv
src/tile_xbar.sv
src/group_noc_top.sv
dv/tb_group_noc.sv
